//--- hw/address_unit.sv
`timescale 1ns/1ps

module address_unit (
	input  logic                clk,
	input  logic                rst_n,
	input  cpu_pkg::ctrl_word_t ctrl,
	input  logic [7:0]          data_bus,
	output logic [15:0]         addr,
	output logic [15:0]         pc,
	output logic [15:0]         ar
);

	logic wr_pc0;
	logic wr_pc1;
	logic wr_ar0;
	logic wr_ar1;

	assign wr_pc0 = ctrl.bus_en && (ctrl.sid == cpu_pkg::ID_PC0);
	assign wr_pc1 = ctrl.bus_en && (ctrl.sid == cpu_pkg::ID_PC1);
	assign wr_ar0 = ctrl.bus_en && (ctrl.sid == cpu_pkg::ID_AR0);
	assign wr_ar1 = ctrl.bus_en && (ctrl.sid == cpu_pkg::ID_AR1);

	// Byte write beats increment
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (wr_pc0) begin
			pc[7:0] <= data_bus; // Jump target, high byte kept
		end else if (wr_pc1) begin
			pc[15:8] <= data_bus;
		end else if (ctrl.pc_inc) begin
			pc <= pc + 16'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ar <= '0;
		end else if (wr_ar0) begin
			ar[7:0] <= data_bus;
		end else if (wr_ar1) begin
			ar[15:8] <= data_bus;
		end else if (ctrl.ar_inc) begin
			ar <= ar + 16'd1;
		end
	end

	assign addr = ctrl.addr_sel ? ar : pc; // Memory address source

endmodule

//--- hw/alu_accumulator.sv
`timescale 1ns/1ps

module alu_accumulator #(
	parameter int DATA_WIDTH = 8
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  cpu_pkg::ctrl_word_t   ctrl,
	input  logic [DATA_WIDTH-1:0] data_bus,
	input  logic [DATA_WIDTH-1:0] b_value,
	output logic [DATA_WIDTH-1:0] acc,
	output cpu_pkg::flags_t       alu_flags
);

	logic [DATA_WIDTH:0]   wide;   // MSB is carry or borrow
	logic [DATA_WIDTH-1:0] result;

	always_comb begin
		case (ctrl.alu_op)
			cpu_pkg::ALU_ADD: wide = {1'b0, acc} + {1'b0, b_value};
			cpu_pkg::ALU_SUB: wide = {1'b0, acc} - {1'b0, b_value}; // Wraps to set borrow
			cpu_pkg::ALU_AND: wide = {1'b0, acc & b_value};
			cpu_pkg::ALU_OR:  wide = {1'b0, acc | b_value};
			cpu_pkg::ALU_XOR: wide = {1'b0, acc ^ b_value};
			cpu_pkg::ALU_NOT: wide = {1'b0, ~acc};
			cpu_pkg::ALU_INC: wide = {1'b0, acc} + (DATA_WIDTH+1)'(1);
			default:          wide = {1'b0, acc} - (DATA_WIDTH+1)'(1); // ALU_DEC
		endcase
	end

	assign result = wide[DATA_WIDTH-1:0];

	// Flags follow the result directly, status reg latches them
	assign alu_flags.sign   = result[DATA_WIDTH-1];
	assign alu_flags.zero   = ~|result;
	assign alu_flags.parity = ^result;
	assign alu_flags.carry  = wide[DATA_WIDTH]; // Zero for logic ops

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc <= '0;
		end else if (ctrl.alu_en) begin
			acc <= result;
		end else if (ctrl.bus_en && ctrl.sid == cpu_pkg::ID_A) begin
			acc <= data_bus; // Bus load
		end
	end

	// ALU update never coincides with a bus load into A
	alu_bus_exclusive: assert property (
		@(posedge clk) disable iff (!rst_n)
		ctrl.alu_en |-> !ctrl.bus_en
	);

endmodule

//--- hw/bus_registers.sv
`timescale 1ns/1ps

module bus_registers #(
	parameter int DATA_WIDTH = 8
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  cpu_pkg::ctrl_word_t   ctrl,
	input  logic [DATA_WIDTH-1:0] acc,
	input  logic [DATA_WIDTH-1:0] mem_rdata,
	input  logic [15:0]           pc,
	input  logic [15:0]           ar,
	input  cpu_pkg::flags_t       alu_flags,
	output logic [DATA_WIDTH-1:0] data_bus,
	output logic [DATA_WIDTH-1:0] ir,
	output logic [DATA_WIDTH-1:0] b_value,
	output cpu_pkg::flags_t       flags
);

	// Bus source select, quiet when no transfer
	always_comb begin
		if (!ctrl.bus_en) begin
			data_bus = '0;
		end else begin
			case (ctrl.mid)
				cpu_pkg::ID_IR:  data_bus = ir;
				cpu_pkg::ID_MEM: data_bus = mem_rdata;
				cpu_pkg::ID_A:   data_bus = acc;
				cpu_pkg::ID_B:   data_bus = b_value;
				cpu_pkg::ID_AR0: data_bus = ar[DATA_WIDTH-1:0];
				cpu_pkg::ID_AR1: data_bus = ar[2*DATA_WIDTH-1:DATA_WIDTH];
				cpu_pkg::ID_PC0: data_bus = pc[DATA_WIDTH-1:0];
				default:         data_bus = pc[2*DATA_WIDTH-1:DATA_WIDTH]; // ID_PC1
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ir      <= '0;
			b_value <= '0;
			flags   <= '0;
		end else begin
			if (ctrl.bus_en && ctrl.sid == cpu_pkg::ID_IR)
				ir <= data_bus;
			if (ctrl.bus_en && ctrl.sid == cpu_pkg::ID_B)
				b_value <= data_bus;
			if (ctrl.alu_en)
				flags <= alu_flags; // Status follows every ALU op
		end
	end

endmodule

//--- hw/control_unit.sv
`timescale 1ns/1ps

module control_unit (
	input  logic                clk,
	input  logic                rst_n,
	input  cpu_pkg::t_state_e   t_state,
	input  logic [7:0]          ir,
	input  cpu_pkg::flags_t     flags,
	input  logic                halt_req,
	output cpu_pkg::ctrl_word_t ctrl,
	output logic                freeze,
	output logic                halted
);

	cpu_pkg::op_type_e   op_type;
	cpu_pkg::bus_id_e    ir_mid;
	cpu_pkg::bus_id_e    ir_sid;
	cpu_pkg::ctrl_word_t raw;      // Word before stall gating
	logic [3:0]          flag_vec;
	logic                is_cj;
	logic                cmp_pass;
	logic                mid_is_mem;
	logic                stall;

	assign op_type    = cpu_pkg::op_type_e'(ir[7:6]);
	assign ir_sid     = cpu_pkg::bus_id_e'(ir[5:3]);
	assign ir_mid     = cpu_pkg::bus_id_e'(ir[2:0]);
	assign is_cj      = ir[5];                   // Only meaningful for OP_SYS
	assign flag_vec   = flags;                   // Index 0 carry up to 3 sign
	assign cmp_pass   = flag_vec[ir[2:1]] ^ ir[0]; // Bit 0 inverts condition
	assign mid_is_mem = (ir_mid == cpu_pkg::ID_MEM);
	assign stall      = halt_req | halted;

	always_comb begin
		raw        = '0;
		raw.alu_op = cpu_pkg::alu_op_e'(ir[2:0]);
		case (t_state)
			cpu_pkg::T1: begin // Opcode fetch from mem[PC]
				raw.bus_en = 1'b1;
				raw.mid    = cpu_pkg::ID_MEM;
				raw.sid    = cpu_pkg::ID_IR;
				raw.pc_inc = 1'b1;
			end
			cpu_pkg::T2: begin
				case (op_type)
					cpu_pkg::OP_MOV: begin
						raw.addr_sel = 1'b1; // Memory side always through AR
						if (!mid_is_mem) begin // Register read, done now
							raw.bus_en    = 1'b1;
							raw.mid       = ir_mid;
							raw.sid       = ir_sid;
							raw.clr_timer = 1'b1;
						end
					end
					cpu_pkg::OP_MVI: ; // Operand read waits for T3
					cpu_pkg::OP_ALU: begin
						raw.alu_en    = 1'b1;
						raw.clr_timer = 1'b1;
					end
					default: begin // OP_SYS
						if (is_cj) begin
							raw.pc_inc    = !cmp_pass; // Skip operand on fail
							raw.clr_timer = !cmp_pass;
						end else begin
							case (cpu_pkg::sys_op_e'(ir[2:0]))
								cpu_pkg::SYS_HLT: raw.hlt = 1'b1; // No clear, timer parks here
								cpu_pkg::SYS_INC_AR: begin
									raw.ar_inc    = 1'b1;
									raw.clr_timer = 1'b1;
								end
								default: raw.clr_timer = 1'b1; // NOP and unused codes
							endcase
						end
					end
				endcase
			end
			cpu_pkg::T3: begin // Memory read: MOV from mem, MVI operand, taken jump
				raw.bus_en    = 1'b1;
				raw.mid       = cpu_pkg::ID_MEM;
				raw.sid       = (op_type == cpu_pkg::OP_SYS) ? cpu_pkg::ID_PC0 : ir_sid;
				raw.addr_sel  = (op_type == cpu_pkg::OP_MOV);
				raw.pc_inc    = (op_type == cpu_pkg::OP_MVI);
				raw.clr_timer = 1'b1;
			end
			default: ; // T0 idle
		endcase
	end

	// Stall kills every strobe, state decode stays frozen
	always_comb begin
		ctrl = raw;
		if (stall) begin
			ctrl.alu_en    = 1'b0;
			ctrl.bus_en    = 1'b0;
			ctrl.pc_inc    = 1'b0;
			ctrl.ar_inc    = 1'b0;
			ctrl.clr_timer = 1'b0;
			ctrl.hlt       = 1'b0;
		end
	end

	assign freeze = stall | ctrl.hlt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			halted <= 1'b0;
		end else if (ctrl.hlt) begin
			halted <= 1'b1; // Sticky until reset
		end
	end

	halted_quiet: assert property (
		@(posedge clk) disable iff (!rst_n)
		halted |-> !(ctrl.bus_en || ctrl.pc_inc || ctrl.ar_inc)
	);

	no_early_clear: assert property (
		@(posedge clk) disable iff (!rst_n)
		(t_state inside {cpu_pkg::T0, cpu_pkg::T1}) |-> !ctrl.clr_timer
	);

endmodule

//--- hw/cpu_pkg.sv
package cpu_pkg;

	// Instruction bits 7:6
	typedef enum logic [1:0] {
		OP_MOV = 2'd0, // Register or memory move
		OP_MVI = 2'd1, // Move immediate
		OP_ALU = 2'd2,
		OP_SYS = 2'd3  // System op or conditional jump (bit 5)
	} op_type_e;

	// Instruction bits 2:0 for ALU ops, result always goes to A
	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
		ALU_XOR, ALU_NOT, ALU_INC, ALU_DEC
	} alu_op_e;

	// Instruction bits 2:0 for system ops with bit 5 clear
	typedef enum logic [2:0] {
		SYS_NOP    = 3'd0,
		SYS_HLT    = 3'd1,
		SYS_INC_AR = 3'd2
	} sys_op_e;

	// Data bus master and slave IDs
	typedef enum logic [2:0] {
		ID_IR, ID_MEM, ID_A, ID_B, ID_AR0, ID_AR1, ID_PC0, ID_PC1
	} bus_id_e;

	typedef enum logic [1:0] {T0, T1, T2, T3} t_state_e;

	// Carry sits at bit 0, sign at bit 3
	typedef struct packed {
		logic sign;
		logic zero;
		logic parity; // Even parity, XOR of result bits
		logic carry;
	} flags_t;

	typedef struct packed {
		alu_op_e alu_op;
		logic    alu_en;    // Update A and latch status
		bus_id_e mid;       // Bus source
		bus_id_e sid;       // Bus destination
		logic    bus_en;    // Transfer strobe
		logic    pc_inc;
		logic    ar_inc;
		logic    addr_sel;  // 0 PC, 1 AR
		logic    clr_timer; // Last cycle of instruction
		logic    hlt;       // HLT executed this cycle
	} ctrl_word_t;

endpackage

//--- hw/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
	parameter int DATA_WIDTH = 8,
	parameter int MEM_DEPTH  = 256
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         halt_req,
	input  logic                         prog_we,
	input  logic [$clog2(MEM_DEPTH)-1:0] prog_addr,
	input  logic [7:0]                   prog_data,
	output logic                         halted,
	output logic [DATA_WIDTH-1:0]        acc,
	output cpu_pkg::flags_t              flags,
	output logic [15:0]                  pc
);

	cpu_pkg::t_state_e   t_state;
	cpu_pkg::ctrl_word_t ctrl;
	cpu_pkg::flags_t     alu_flags;
	logic                freeze;
	logic [DATA_WIDTH-1:0] data_bus;
	logic [DATA_WIDTH-1:0] ir;
	logic [DATA_WIDTH-1:0] b_value;
	logic [7:0]          mem_rdata;
	logic [15:0]         addr;
	logic [15:0]         ar;

	t_state_timer u_timer (.clk(clk), .rst_n(rst_n), .clr_timer(ctrl.clr_timer),
		.freeze(freeze), .t_state(t_state));

	control_unit u_ctrl (.clk(clk), .rst_n(rst_n), .t_state(t_state), .ir(ir),
		.flags(flags), .halt_req(halt_req), .ctrl(ctrl), .freeze(freeze), .halted(halted));

	alu_accumulator #(.DATA_WIDTH(DATA_WIDTH)) u_alu (.clk(clk), .rst_n(rst_n),
		.ctrl(ctrl), .data_bus(data_bus), .b_value(b_value), .acc(acc), .alu_flags(alu_flags));

	address_unit u_addr (.clk(clk), .rst_n(rst_n), .ctrl(ctrl), .data_bus(data_bus),
		.addr(addr), .pc(pc), .ar(ar));

	program_memory #(.MEM_DEPTH(MEM_DEPTH)) u_mem (.clk(clk), .ctrl(ctrl), .addr(addr),
		.data_bus(data_bus), .prog_we(prog_we), .prog_addr(prog_addr),
		.prog_data(prog_data), .mem_rdata(mem_rdata));

	bus_registers #(.DATA_WIDTH(DATA_WIDTH)) u_regs (.clk(clk), .rst_n(rst_n), .ctrl(ctrl),
		.acc(acc), .mem_rdata(mem_rdata), .pc(pc), .ar(ar), .alu_flags(alu_flags),
		.data_bus(data_bus), .ir(ir), .b_value(b_value), .flags(flags));

endmodule

//--- hw/program_memory.sv
`timescale 1ns/1ps

module program_memory #(
	parameter int MEM_DEPTH = 256
) (
	input  logic                         clk,
	input  cpu_pkg::ctrl_word_t          ctrl,
	input  logic [15:0]                  addr,
	input  logic [7:0]                   data_bus,
	input  logic                         prog_we,
	input  logic [$clog2(MEM_DEPTH)-1:0] prog_addr,
	input  logic [7:0]                   prog_data,
	output logic [7:0]                   mem_rdata
);

	localparam int AW = $clog2(MEM_DEPTH);

	logic [7:0] mem [MEM_DEPTH];
	logic       bus_wr;

	assign bus_wr    = ctrl.bus_en && (ctrl.sid == cpu_pkg::ID_MEM);
	assign mem_rdata = mem[addr[AW-1:0]]; // Async read, low address bits

	always_ff @(posedge clk) begin
		if (prog_we) begin
			mem[prog_addr] <= prog_data; // Loader port, CPU in reset
		end else if (bus_wr) begin
			mem[addr[AW-1:0]] <= data_bus;
		end
	end

	// Loader only runs while the CPU is held idle
	no_write_clash: assert property (@(posedge clk) !(bus_wr && prog_we));

endmodule

//--- hw/t_state_timer.sv
`timescale 1ns/1ps

module t_state_timer (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              clr_timer,
	input  logic              freeze,
	output cpu_pkg::t_state_e t_state
);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			t_state <= cpu_pkg::T0;
		end else if (clr_timer) begin
			t_state <= cpu_pkg::T0; // Next instruction starts idle
		end else if (!freeze) begin
			t_state <= cpu_pkg::t_state_e'(t_state + 2'd1);
		end
	end

	// Control unit must close every instruction at T3 at the latest
	t3_needs_clear: assert property (
		@(posedge clk) disable iff (!rst_n)
		(t_state == cpu_pkg::T3 && !freeze) |-> clr_timer
	);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -f src.f --top-module tb_cpu -Mdir obj_dir
./obj_dir/Vtb_cpu | tee sim.log
if grep -q "Verification passed" sim.log; then
	echo "Simulation PASS"
else
	echo "Simulation FAIL"
	exit 1
fi

//--- sim/cpu_vectors.hex
// One test per line, 41 hex digits: 16 program bytes (address 0 first), acc,
// flags {sign,zero,parity,carry}, PC after HLT, halt_req window start (00 none)
50F0582080C100000000000000000000103000600
5005580781C100000000000000000000FEB000600
50CC583382C100000000000000000000004000600
5081580283C10000000000000000000083A000600
50FF580F84C100000000000000000000F08000600
5054580085C100000000000000000000ABA000600
50FF580086C100000000000000000000005000600
5000580087C100000000000000000000FF9000600
6040503C0A1A50001180C10000000000780000B00
600CC211C10000000000000011770000770000500
50F0582080E00A5011C15022C1000000223000D00
5001580181E50A5011C15022C1000000114000A00
5001580180E70A5011C15022C1000000222000D00
5003580083E20A5011C15022C1000000110000A00
6040503C0A1A50001180C10000000000780000B04

//--- sim/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

	localparam int NUM_TESTS   = 15;
	localparam int CYC_LIMIT   = NUM_TESTS * 64; // Running cycles over all tests
	localparam int HOLD_CYCLES = 20;             // Post-HLT watch
	localparam int REQ_LEN     = 6;              // halt_req high time

	logic        clk = 1'b0;
	logic        rst_n;
	logic        halt_req;
	logic        prog_we;
	logic [7:0]  prog_addr;
	logic [7:0]  prog_data;
	logic        halted;
	logic [7:0]  acc;
	logic [3:0]  flags; // {sign, zero, parity, carry}
	logic [15:0] pc;

	logic [163:0] vectors [NUM_TESTS]; // Program, acc, flags, pc, halt window
	int           run_cycles = 0;
	int           test_idx;
	int unsigned  seed_draw;

	cpu_top #(.DATA_WIDTH(8), .MEM_DEPTH(256)) uut (
		.clk(clk), .rst_n(rst_n), .halt_req(halt_req), .prog_we(prog_we),
		.prog_addr(prog_addr), .prog_data(prog_data), .halted(halted),
		.acc(acc), .flags(flags), .pc(pc)
	);

	always #50 clk = ~clk; // 100 ns period

	// Counts only while the CPU runs, reset and loading are excluded
	always @(posedge clk) begin
		if (rst_n) begin
			run_cycles <= run_cycles + 1;
			if (run_cycles >= CYC_LIMIT) begin
				$display("Timeout: the CPU did not halt within %0d running cycles", CYC_LIMIT);
				$display("Verification failed");
				$fatal(1, "simulation timed out");
			end
		end
	end

	task automatic stop_on_error(input string line);
		$display("%s", line);
		$display("Verification failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic run_test(input int idx);
		logic [163:0] rec;
		logic [7:0]   exp_acc;
		logic [3:0]   exp_flags;
		logic [15:0]  exp_pc;
		logic [15:0]  held_pc;
		int           req_at;
		int           cyc;
		int           i;
		rec       = vectors[idx];
		exp_acc   = rec[35:28];
		exp_flags = rec[27:24];
		exp_pc    = rec[23:8];
		req_at    = 0;
		if (rec[7:0] != 8'd0)
			req_at = int'(rec[7:0]) + int'($urandom % 4); // Somewhere in a 4-cycle window
		rst_n = 1'b0;
		repeat (4) @(negedge clk);
		for (i = 0; i < 16; i++) begin // Loader runs with CPU still in reset
			prog_we   = 1'b1;
			prog_addr = 8'(i);
			prog_data = rec[163-8*i -: 8];
			@(negedge clk);
		end
		prog_we = 1'b0;
		rst_n   = 1'b1;
		cyc     = 0;
		while (!halted) begin
			@(negedge clk);
			cyc++;
			if (req_at != 0 && cyc == req_at) begin
				halt_req = 1'b1;
				held_pc  = pc;
				repeat (REQ_LEN) begin
					@(negedge clk);
					assert (pc == held_pc) else stop_on_error($sformatf(
						"ERROR pc = %h, expected %h while halt_req high (test %0d)",
						pc, held_pc, idx));
				end
				halt_req = 1'b0; // Program resumes where it stopped
			end
		end
		assert (acc == exp_acc) else stop_on_error($sformatf(
			"ERROR acc = %h, expected %h (test %0d)", acc, exp_acc, idx));
		assert (flags == exp_flags) else stop_on_error($sformatf(
			"ERROR flags = %h, expected %h (test %0d)", flags, exp_flags, idx));
		assert (pc == exp_pc) else stop_on_error($sformatf(
			"ERROR pc = %h, expected %h after HLT (test %0d)", pc, exp_pc, idx));
		held_pc = pc;
		repeat (HOLD_CYCLES) begin // HLT must be sticky
			@(negedge clk);
			assert (halted) else stop_on_error($sformatf(
				"Test %0d: halted dropped after the HLT instruction", idx));
			assert (pc == held_pc) else stop_on_error($sformatf(
				"ERROR pc = %h, expected %h while halted (test %0d)", pc, held_pc, idx));
		end
	endtask

	initial begin
		rst_n     = 1'b0;
		halt_req  = 1'b0;
		prog_we   = 1'b0;
		prog_addr = 8'h00;
		prog_data = 8'h00;
		seed_draw = $urandom(32'h60172650); // Seeds the generator once
		$readmemh("sim/cpu_vectors.hex", vectors);
		@(negedge clk);
		for (test_idx = 0; test_idx < NUM_TESTS; test_idx++)
			run_test(test_idx);
		$display("Verification passed");
		$finish;
	end

endmodule

//--- src.f
hw/cpu_pkg.sv
hw/t_state_timer.sv
hw/control_unit.sv
hw/alu_accumulator.sv
hw/address_unit.sv
hw/program_memory.sv
hw/bus_registers.sv
hw/cpu_top.sv
sim/tb_cpu.sv
